//--- build.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/hazard_unit.sv
logic/rv_core_top.sv
sim/tb_core.sv

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     if_pc_i,
    input  word_t     if_instr_i,
    input  logic      bubble_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_rd_i,
    input  word_t     wb_data_i,
    output reg_addr_t id_rs1_addr_o,
    output reg_addr_t id_rs2_addr_o,
    output word_t     ex_pc_o,
    output word_t     ex_rs1_data_o,
    output word_t     ex_rs2_data_o,
    output word_t     ex_imm_o,
    output reg_addr_t ex_rs1_addr_o,
    output reg_addr_t ex_rs2_addr_o,
    output reg_addr_t ex_rd_o,
    output alu_op_e   ex_alu_op_o,
    output logic      ex_use_imm_o,
    output logic      ex_mem_read_o,
    output logic      ex_mem_write_o,
    output logic      ex_reg_write_o,
    output logic      ex_branch_o,
    output logic      ex_branch_ne_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm;
    word_t      rs1_data, rs2_data;
    alu_op_e    alu_op;
    logic       use_imm, mem_read, mem_write, reg_write, branch, uses_rs2;

    assign opcode = opcode_e'(if_instr_i[OPCODE_MSB:OPCODE_LSB]);
    assign funct3 = if_instr_i[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = if_instr_i[FUNCT7_MSB:FUNCT7_LSB];

    assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
    assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
    assign imm_b = {{19{if_instr_i[31]}}, if_instr_i[31], if_instr_i[7],
                    if_instr_i[30:25], if_instr_i[11:8], 1'b0};

    assign id_rs1_addr_o = if_instr_i[RS1_MSB:RS1_LSB];
    // rs2 field is immediate bits for I-type so it is hidden from the hazard unit
    assign id_rs2_addr_o = uses_rs2 ? if_instr_i[RS2_MSB:RS2_LSB] : '0;

    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (id_rs1_addr_o),
        .rs2_addr_i (id_rs2_addr_o),
        .we_i       (wb_we_i),
        .rd_i       (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        uses_rs2  = 1'b0;
        imm       = '0;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_IMM: begin  // ADDI only
                reg_write = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_i;
            end
            OP_LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                use_imm   = 1'b1;
                imm       = imm_i;
            end
            OP_STORE: begin
                mem_write = 1'b1;
                use_imm   = 1'b1;
                uses_rs2  = 1'b1;
                imm       = imm_s;
            end
            OP_BRANCH: begin
                branch   = 1'b1;
                uses_rs2 = 1'b1;
                imm      = imm_b;
            end
            default: ;  // All-zero word lands here as a bubble
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_pc_o        <= '0;
            ex_rs1_data_o  <= '0;
            ex_rs2_data_o  <= '0;
            ex_imm_o       <= '0;
            ex_rs1_addr_o  <= '0;
            ex_rs2_addr_o  <= '0;
            ex_rd_o        <= '0;
            ex_alu_op_o    <= ALU_ADD;
            ex_use_imm_o   <= 1'b0;
            ex_branch_ne_o <= 1'b0;
            ex_mem_read_o  <= 1'b0;
            ex_mem_write_o <= 1'b0;
            ex_reg_write_o <= 1'b0;
            ex_branch_o    <= 1'b0;
        end else begin
            ex_pc_o        <= if_pc_i;
            ex_rs1_data_o  <= rs1_data;
            ex_rs2_data_o  <= rs2_data;
            ex_imm_o       <= imm;
            ex_rs1_addr_o  <= id_rs1_addr_o;
            ex_rs2_addr_o  <= id_rs2_addr_o;
            ex_rd_o        <= if_instr_i[RD_MSB:RD_LSB];
            ex_alu_op_o    <= alu_op;
            ex_use_imm_o   <= use_imm;
            ex_branch_ne_o <= funct3[0];  // BNE
            ex_mem_read_o  <= mem_read  & ~bubble_i;
            ex_mem_write_o <= mem_write & ~bubble_i;
            ex_reg_write_o <= reg_write & ~bubble_i;
            ex_branch_o    <= branch    & ~bubble_i;
        end
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     ex_pc_i,
    input  word_t     ex_rs1_data_i,
    input  word_t     ex_rs2_data_i,
    input  word_t     ex_imm_i,
    input  reg_addr_t ex_rd_i,
    input  alu_op_e   ex_alu_op_i,
    input  logic      ex_use_imm_i,
    input  logic      ex_mem_read_i,
    input  logic      ex_mem_write_i,
    input  logic      ex_reg_write_i,
    input  logic      ex_branch_i,
    input  logic      ex_branch_ne_i,
    input  fwd_sel_e  fwd_a_i,
    input  fwd_sel_e  fwd_b_i,
    input  word_t     wb_data_i,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output word_t     mem_alu_o,
    output word_t     mem_store_data_o,
    output reg_addr_t mem_rd_o,
    output logic      mem_read_o,
    output logic      mem_write_o,
    output logic      mem_reg_write_o
);

    word_t op_a;
    word_t op_b_reg;  // rs2 after forwarding, also store data
    word_t op_b;
    word_t alu_res;

    //////////////////////////////
    // Forwarding muxes
    //////////////////////////////
    always_comb begin
        case (fwd_a_i)
            FWD_MEM: op_a = mem_alu_o;
            FWD_WB:  op_a = wb_data_i;
            default: op_a = ex_rs1_data_i;
        endcase
        case (fwd_b_i)
            FWD_MEM: op_b_reg = mem_alu_o;
            FWD_WB:  op_b_reg = wb_data_i;
            default: op_b_reg = ex_rs2_data_i;
        endcase
    end

    assign op_b = ex_use_imm_i ? ex_imm_i : op_b_reg;

    always_comb begin
        case (ex_alu_op_i)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
            default: alu_res = op_a + op_b;
        endcase
    end

    // BEQ on equal and BNE on not equal
    assign branch_taken_o  = ex_branch_i & ((op_a == op_b_reg) ^ ex_branch_ne_i);
    assign branch_target_o = ex_pc_i + ex_imm_i;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_alu_o        <= '0;
            mem_store_data_o <= '0;
            mem_rd_o         <= '0;
            mem_read_o       <= 1'b0;
            mem_write_o      <= 1'b0;
            mem_reg_write_o  <= 1'b0;
        end else begin
            mem_alu_o        <= alu_res;
            mem_store_data_o <= op_b_reg;
            mem_rd_o         <= ex_rd_i;
            mem_read_o       <= ex_mem_read_i;
            mem_write_o      <= ex_mem_write_i;
            mem_reg_write_o  <= ex_reg_write_i;
        end
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  logic                          branch_taken_i,
    input  word_t                         branch_target_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  word_t                         imem_wdata_i,
    output word_t                         if_pc_o,
    output word_t                         if_instr_o
);

    localparam int IA_W = $clog2(IMEM_DEPTH);

    word_t imem [IMEM_DEPTH];
    word_t pc_q;
    word_t pc_next;
    word_t fetch_word;

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    assign fetch_word = imem[pc_q[IA_W+1:2]];  // Word address

    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;  // Redirect wins over any hold
        end else if (stall_i || !run_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    //////////////////////////////
    // PC and IF/ID register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= '0;
            if_pc_o    <= '0;
            if_instr_o <= '0;
        end else begin
            pc_q <= pc_next;
            if (flush_i) begin
                if_instr_o <= '0;  // Wrong-path instruction dropped
            end else if (!stall_i) begin
                if_pc_o    <= pc_q;
                if_instr_o <= run_i ? fetch_word : '0;
            end
        end
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  reg_addr_t id_rs1_addr_i,
    input  reg_addr_t id_rs2_addr_i,
    input  reg_addr_t ex_rs1_addr_i,
    input  reg_addr_t ex_rs2_addr_i,
    input  reg_addr_t ex_rd_i,
    input  logic      ex_mem_read_i,
    input  logic      branch_taken_i,
    input  reg_addr_t mem_rd_i,
    input  reg_addr_t wb_rd_i,
    input  logic      mem_reg_write_i,
    input  logic      wb_we_i,
    output logic      stall_o,
    output logic      flush_o,
    output fwd_sel_e  fwd_a_o,
    output fwd_sel_e  fwd_b_o
);

    // Youngest producer wins
    function automatic fwd_sel_e pick_src(
        input reg_addr_t src,
        input logic      mem_we,
        input reg_addr_t mem_rd,
        input logic      wb_we,
        input reg_addr_t wb_rd
    );
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (mem_we && mem_rd != '0 && mem_rd == src) begin
            sel = FWD_MEM;
        end else if (wb_we && wb_rd != '0 && wb_rd == src) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    // Load in execute feeding the instruction in decode
    assign stall_o = ex_mem_read_i && (ex_rd_i != '0) &&
                     (ex_rd_i == id_rs1_addr_i || ex_rd_i == id_rs2_addr_i);

    assign flush_o = branch_taken_i;

    assign fwd_a_o = pick_src(ex_rs1_addr_i, mem_reg_write_i, mem_rd_i,
                              wb_we_i, wb_rd_i);
    assign fwd_b_o = pick_src(ex_rs2_addr_i, mem_reg_write_i, mem_rd_i,
                              wb_we_i, wb_rd_i);

endmodule

//--- logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_alu_i,
    input  word_t     mem_store_data_i,
    input  reg_addr_t mem_rd_i,
    input  logic      mem_read_i,
    input  logic      mem_write_i,
    input  logic      mem_reg_write_i,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    localparam int DA_W = $clog2(DMEM_DEPTH);

    word_t dmem [DMEM_DEPTH];
    word_t load_data;
    word_t wb_alu_q;
    word_t wb_load_q;
    logic  wb_is_load_q;
    logic  wb_write_q;

    assign load_data = dmem[mem_alu_i[DA_W+1:2]];  // Byte address to word index

    always_ff @(posedge clk) begin
        if (mem_write_i) begin
            dmem[mem_alu_i[DA_W+1:2]] <= mem_store_data_i;
        end
    end

    //////////////////////////////
    // MEM/WB register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_alu_q     <= '0;
            wb_load_q    <= '0;
            wb_rd_o      <= '0;
            wb_is_load_q <= 1'b0;
            wb_write_q   <= 1'b0;
        end else begin
            wb_alu_q     <= mem_alu_i;
            wb_load_q    <= load_data;
            wb_rd_o      <= mem_rd_i;
            wb_is_load_q <= mem_read_i;
            wb_write_q   <= mem_reg_write_i;
        end
    end

    assign wb_data_o = wb_is_load_q ? wb_load_q : wb_alu_q;
    assign wb_we_o   = wb_write_q && (wb_rd_o != '0);  // No writeback to x0

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    input  logic      we_i,
    input  reg_addr_t rd_i,
    input  word_t     rd_data_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin  // x0 never written
            regs[rd_i] <= rd_data_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && rd_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && rd_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          run_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  word_t                         imem_wdata_i,
    output logic                          wb_valid_o,
    output reg_addr_t                     wb_rd_o,
    output word_t                         wb_data_o
);

    // IF/ID
    word_t     if_pc, if_instr;
    // Decode to hazard unit and ID/EX
    reg_addr_t id_rs1_addr, id_rs2_addr;
    word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rs1_addr, ex_rs2_addr, ex_rd;
    alu_op_e   ex_alu_op;
    logic      ex_use_imm, ex_mem_read, ex_mem_write, ex_reg_write;
    logic      ex_branch, ex_branch_ne;
    // Execute outputs and EX/MEM
    logic      branch_taken;
    word_t     branch_target;
    word_t     mem_alu, mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_read, mem_write, mem_reg_write;
    // Writeback
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;
    // Hazard control
    logic      stall, flush, id_bubble;
    fwd_sel_e  fwd_a, fwd_b;

    assign id_bubble = stall | flush;

    assign wb_valid_o = wb_we;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

    //////////////////////////////
    // Pipeline stages
    //////////////////////////////
    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk             (clk),
        .rst             (rst),
        .run_i           (run_i),
        .stall_i         (stall),
        .flush_i         (flush),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .imem_we_i       (imem_we_i),
        .imem_addr_i     (imem_addr_i),
        .imem_wdata_i    (imem_wdata_i),
        .if_pc_o         (if_pc),
        .if_instr_o      (if_instr)
    );

    decode_stage u_decode (
        .clk            (clk),
        .rst            (rst),
        .if_pc_i        (if_pc),
        .if_instr_i     (if_instr),
        .bubble_i       (id_bubble),
        .wb_we_i        (wb_we),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .id_rs1_addr_o  (id_rs1_addr),
        .id_rs2_addr_o  (id_rs2_addr),
        .ex_pc_o        (ex_pc),
        .ex_rs1_data_o  (ex_rs1_data),
        .ex_rs2_data_o  (ex_rs2_data),
        .ex_imm_o       (ex_imm),
        .ex_rs1_addr_o  (ex_rs1_addr),
        .ex_rs2_addr_o  (ex_rs2_addr),
        .ex_rd_o        (ex_rd),
        .ex_alu_op_o    (ex_alu_op),
        .ex_use_imm_o   (ex_use_imm),
        .ex_mem_read_o  (ex_mem_read),
        .ex_mem_write_o (ex_mem_write),
        .ex_reg_write_o (ex_reg_write),
        .ex_branch_o    (ex_branch),
        .ex_branch_ne_o (ex_branch_ne)
    );

    execute_stage u_execute (
        .clk              (clk),
        .rst              (rst),
        .ex_pc_i          (ex_pc),
        .ex_rs1_data_i    (ex_rs1_data),
        .ex_rs2_data_i    (ex_rs2_data),
        .ex_imm_i         (ex_imm),
        .ex_rd_i          (ex_rd),
        .ex_alu_op_i      (ex_alu_op),
        .ex_use_imm_i     (ex_use_imm),
        .ex_mem_read_i    (ex_mem_read),
        .ex_mem_write_i   (ex_mem_write),
        .ex_reg_write_i   (ex_reg_write),
        .ex_branch_i      (ex_branch),
        .ex_branch_ne_i   (ex_branch_ne),
        .fwd_a_i          (fwd_a),
        .fwd_b_i          (fwd_b),
        .wb_data_i        (wb_data),
        .branch_taken_o   (branch_taken),
        .branch_target_o  (branch_target),
        .mem_alu_o        (mem_alu),
        .mem_store_data_o (mem_store_data),
        .mem_rd_o         (mem_rd),
        .mem_read_o       (mem_read),
        .mem_write_o      (mem_write),
        .mem_reg_write_o  (mem_reg_write)
    );

    memory_stage #(.DMEM_DEPTH(DMEM_DEPTH)) u_memory (
        .clk              (clk),
        .rst              (rst),
        .mem_alu_i        (mem_alu),
        .mem_store_data_i (mem_store_data),
        .mem_rd_i         (mem_rd),
        .mem_read_i       (mem_read),
        .mem_write_i      (mem_write),
        .mem_reg_write_i  (mem_reg_write),
        .wb_we_o          (wb_we),
        .wb_rd_o          (wb_rd),
        .wb_data_o        (wb_data)
    );

    hazard_unit u_hazard (
        .id_rs1_addr_i   (id_rs1_addr),
        .id_rs2_addr_i   (id_rs2_addr),
        .ex_rs1_addr_i   (ex_rs1_addr),
        .ex_rs2_addr_i   (ex_rs2_addr),
        .ex_rd_i         (ex_rd),
        .ex_mem_read_i   (ex_mem_read),
        .branch_taken_i  (branch_taken),
        .mem_rd_i        (mem_rd),
        .wb_rd_i         (wb_rd),
        .mem_reg_write_i (mem_reg_write),
        .wb_we_i         (wb_we),
        .stall_o         (stall),
        .flush_o         (flush),
        .fwd_a_o         (fwd_a),
        .fwd_b_o         (fwd_b)
    );

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;     // Register value, ALU result or instruction
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE,  // ID/EX register value
        FWD_MEM,   // EX/MEM result
        FWD_WB     // Writeback value
    } fwd_sel_e;

    //////////////////////////////
    // Instruction field positions
    //////////////////////////////
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

endpackage

//--- sim/core_input.txt
// Program length followed by one instruction word per line
// Writeback count followed by one line per writeback with register index and value
00000021  // 33 program words
00C00093  // 00 addi x1, x0, 12
FFD00113  // 01 addi x2, x0, -3
002081B3  // 02 add  x3, x1, x2
40208233  // 03 sub  x4, x1, x2
002272B3  // 04 and  x5, x4, x2
0011C333  // 05 xor  x6, x3, x1
001363B3  // 06 or   x7, x6, x1
00112433  // 07 slt  x8, x2, x1
0020A4B3  // 08 slt  x9, x1, x2
FF900593  // 09 addi x11, x0, -7
0025A533  // 10 slt  x10, x11, x2
00B12633  // 11 slt  x12, x2, x11
06408013  // 12 addi x0, x1, 100
001006B3  // 13 add  x13, x0, x1
04000713  // 14 addi x14, x0, 64
00772223  // 15 sw   x7, 4(x14)
00472783  // 16 lw   x15, 4(x14)
00178833  // 17 add  x16, x15, x1
00472023  // 18 sw   x4, 0(x14)
00072883  // 19 lw   x17, 0(x14)
41088933  // 20 sub  x18, x17, x16
00D08663  // 21 beq  x1, x13, +12
00100A13  // 22 addi x20, x0, 1
00200A93  // 23 addi x21, x0, 2
00B11663  // 24 bne  x2, x11, +12
00300B13  // 25 addi x22, x0, 3
00400B93  // 26 addi x23, x0, 4
00208663  // 27 beq  x1, x2, +12
04D00C13  // 28 addi x24, x0, 77
FFFC0C93  // 29 addi x25, x24, -1
00000063  // 30 beq  x0, x0, 0
00000000  // 31 bubble
00000000  // 32 bubble
00000014  // 20 writebacks
01 0000000C
02 FFFFFFFD
03 00000009
04 0000000F
05 0000000D
06 00000005
07 0000000D
08 00000001
09 00000000
0B FFFFFFF9
0A 00000001
0C 00000000
0D 0000000C
0E 00000040
0F 0000000D
10 00000019
11 0000000F
12 FFFFFFF6
18 0000004D
19 0000004C

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int IMEM_AW      = $clog2(IMEM_DEPTH);
    localparam int FILE_WORDS   = 128;
    localparam int DRAIN_CYCLES = 12;  // Quiet time after the last writeback

    logic               clk = 1'b0;
    logic               rst;
    logic               run;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    word_t              imem_wdata;
    logic               wb_valid;
    reg_addr_t          wb_rd;
    word_t              wb_data;

    word_t       file_words [FILE_WORDS];
    int unsigned prog_len;
    int unsigned pair_count;
    int unsigned pair_base;  // Index of the first expected pair
    int unsigned match_count;
    int unsigned cycle_count;
    int unsigned cycle_limit;

    rv_core_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .run_i        (run),
        .imem_we_i    (imem_we),
        .imem_addr_i  (imem_addr),
        .imem_wdata_i (imem_wdata),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    always #10 clk = ~clk;  // 20 ns period

    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    //////////////////////////////
    // Stimulus file
    //////////////////////////////
    task automatic read_stimulus();
        $readmemh("sim/core_input.txt", file_words);
        assert (!$isunknown(file_words[0])) else begin
            $display("Stimulus file sim/core_input.txt is missing or has no program length");
            stop_with_failure();
        end
        prog_len = file_words[0];
        assert (prog_len > 0 && prog_len <= IMEM_DEPTH && prog_len + 2 < FILE_WORDS) else begin
            $display("Program length %0d does not fit the instruction memory", prog_len);
            stop_with_failure();
        end
        assert (!$isunknown(file_words[prog_len + 1])) else begin
            $display("Stimulus file has no writeback count after the program words");
            stop_with_failure();
        end
        pair_count = file_words[prog_len + 1];
        pair_base  = prog_len + 2;
        assert (pair_base + 2 * pair_count <= FILE_WORDS) else begin
            $display("Stimulus file lists more writebacks than the testbench can hold");
            stop_with_failure();
        end
    endtask

    // Program goes in with run low and random idle cycles between words
    task automatic load_program();
        int unsigned gap;
        for (int i = 0; i < prog_len; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = IMEM_AW'(i);
            imem_wdata = file_words[1 + i];
            @(negedge clk);
            imem_we    = 1'b0;
        end
    endtask

    //////////////////////////////
    // Writeback trace check
    //////////////////////////////
    task automatic check_writeback();
        reg_addr_t exp_rd;
        word_t     exp_data;
        assert (match_count < pair_count) else begin
            $display("Unexpected writeback to x%0d at %0t after all %0d expected writebacks",
                     wb_rd, $time, pair_count);
            stop_with_failure();
        end
        exp_rd   = reg_addr_t'(file_words[pair_base + 2 * match_count]);
        exp_data = file_words[pair_base + 2 * match_count + 1];
        assert (wb_rd === exp_rd) else begin
            $display("FAILED at %0t: wb_rd_o expected %0d, got %0d", $time, exp_rd, wb_rd);
            stop_with_failure();
        end
        assert (wb_data === exp_data) else begin
            $display("FAILED at %0t: wb_data_o (x%0d) expected %08h, got %08h",
                     $time, exp_rd, exp_data, wb_data);
            stop_with_failure();
        end
        match_count++;
    endtask

    // MEM/WB outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            assert (!$isunknown(wb_valid)) else begin
                $display("FAILED at %0t: wb_valid_o expected 0 or 1, got %b", $time, wb_valid);
                stop_with_failure();
            end
            if (wb_valid === 1'b1) begin
                check_writeback();
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int unsigned seed_word;
        seed_word   = $urandom(32'h6a138566);  // One seed for the whole run
        rst         = 1'b1;
        run         = 1'b0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        match_count = 0;
        cycle_count = 0;

        read_stimulus();
        repeat (2) @(negedge clk);
        rst = 1'b0;

        load_program();
        run = 1'b1;

        // Count on the rising edge so the checker's updates never share a time step
        cycle_limit = 20 * prog_len + 50;
        while (match_count < pair_count && cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        if (match_count == pair_count) begin
            repeat (DRAIN_CYCLES) @(posedge clk);  // Catch stray writebacks
        end

        if (match_count == pair_count) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Timeout after %0d cycles with %0d of %0d writebacks seen",
                     cycle_count, match_count, pair_count);
            stop_with_failure();
        end
    end

endmodule
